// ==== logic/fix_consts.svh ====
// FIX session receive constants: protocol characters, tag numbers and field widths
`ifndef FIX_CONSTS_SVH
`define FIX_CONSTS_SVH

// protocol characters
`define FIX_SOH            8'h01      // field delimiter
`define FIX_EQ             8'h3d      // '=' between tag and value
`define FIX_CHAR_Y         8'h59      // 'Y' for boolean flags
`define FIX_VER_PREFIX     "FIX.4."   // BeginString without minor digit
`define FIX_VER_MAX        "3"        // highest supported minor version

// field widths
`define FIX_TAG_W          16
`define FIX_VAL_W          64         // eight characters, right aligned
`define FIX_NUM_W          32         // decimal value of a field
`define FIX_SEQ_W          32

// session tag numbers
`define T_BEGIN_STRING     16'd8
`define T_BODY_LENGTH      16'd9
`define T_MSG_TYPE         16'd35
`define T_MSG_SEQ_NUM      16'd34
`define T_SENDER_COMP_ID   16'd49
`define T_TARGET_COMP_ID   16'd56
`define T_SENDING_TIME     16'd52
`define T_POSS_DUP         16'd43
`define T_GAP_FILL         16'd123
`define T_NEW_SEQ_NO       16'd36
`define T_CHECKSUM         16'd10

`endif

// ==== logic/fix_session_pkg.sv ====
// FIX session receive types: message types, error classes, parsed fields and verdicts
`default_nettype none

`include "fix_consts.svh"

package fix_session_pkg;

	typedef enum logic [3:0] {
		mt_none           = 4'd0,
		mt_logon          = 4'd1, // 'A'
		mt_heartbeat      = 4'd2, // '0'
		mt_test_request   = 4'd3, // '1'
		mt_resend_request = 4'd4, // '2'
		mt_reject         = 4'd5, // '3'
		mt_seq_reset      = 4'd6, // '4' without gap fill
		mt_gap_fill       = 4'd7, // '4' with 123=Y
		mt_logout         = 4'd8  // '5'
	} msg_type_e;

	// lower value wins when several apply
	typedef enum logic [3:0] {
		err_ok                   = 4'd0,
		err_garbled              = 4'd1,
		err_unsupported_version  = 4'd2,
		err_invalid_msg_type     = 4'd3,
		err_required_tag_missing = 4'd4,
		err_seq_low              = 4'd5,
		err_seq_high             = 4'd6
	} err_e;

	typedef enum logic [3:0] {
		vs_idle, vs_version, vs_body_tag, vs_body_val, vs_type_tag,
		vs_type_val, vs_seq_tag, vs_seq_val, vs_fields, vs_wait_sum
	} vstate_e;

	typedef struct packed {
		logic [`FIX_TAG_W-1:0] tag;
		logic [`FIX_VAL_W-1:0] raw; // last eight characters
		logic [`FIX_NUM_W-1:0] num; // decimal value, 0 without digits
		logic                  som; // tag 8
		logic                  eom; // tag 10
	} field_s;

	typedef struct packed {
		msg_type_e             mtype;
		err_e                  err;
		logic [`FIX_SEQ_W-1:0] seq;
		logic [`FIX_SEQ_W-1:0] new_seq;
		logic                  poss_dup;
	} verdict_s;

endpackage

`default_nettype wire

// ==== logic/fix_tag_parser.sv ====
// FIX tag parser: splits the byte stream into tag and value strobes with message markers
`default_nettype none

`include "fix_consts.svh"

module fix_tag_parser import fix_session_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       byte_valid_i,
	input  logic [7:0] byte_i,
	output logic       tag_valid_o,
	output logic       val_valid_o,
	output field_s     field_o
);

	logic                  in_tag_q;  // low while inside a value
	logic [`FIX_TAG_W-1:0] tag_acc_q;
	logic [`FIX_VAL_W-1:0] raw_acc_q;
	logic [`FIX_NUM_W-1:0] num_acc_q;
	logic                  is_digit;
	logic [3:0]            digit;
	logic                  got_eq;
	logic                  got_soh;

	assign is_digit = (byte_i >= "0") && (byte_i <= "9");
	assign digit    = byte_i[3:0]; // ascii digits hold their value in the low nibble
	assign got_eq   = byte_valid_i && in_tag_q && (byte_i == `FIX_EQ);
	assign got_soh  = byte_valid_i && !in_tag_q && (byte_i == `FIX_SOH);

	always_ff @(posedge clk) begin
		if (rst) begin
			in_tag_q    <= 1'b1;
			tag_acc_q   <= '0;
			tag_valid_o <= 1'b0;
			val_valid_o <= 1'b0;
		end else begin
			tag_valid_o <= got_eq;
			val_valid_o <= got_soh;
			if (got_eq) begin
				in_tag_q <= 1'b0;
			end else if (got_soh) begin
				in_tag_q  <= 1'b1;
				tag_acc_q <= '0;
			end else if (byte_valid_i && in_tag_q) begin
				if (byte_i == `FIX_SOH)
					tag_acc_q <= '0; // empty field, start over
				else if (is_digit)
					tag_acc_q <= tag_acc_q * `FIX_TAG_W'(10) + `FIX_TAG_W'(digit);
			end
		end
	end

	// value side, only meaningful between '=' and SOH
	always_ff @(posedge clk) begin
		if (got_eq) begin
			field_o.tag <= tag_acc_q;
			field_o.som <= (tag_acc_q == `T_BEGIN_STRING);
			field_o.eom <= (tag_acc_q == `T_CHECKSUM);
			raw_acc_q   <= '0;
			num_acc_q   <= '0;
		end else if (got_soh) begin
			field_o.raw <= raw_acc_q;
			field_o.num <= num_acc_q;
		end else if (byte_valid_i && !in_tag_q) begin
			raw_acc_q <= {raw_acc_q[`FIX_VAL_W-9:0], byte_i}; // keeps the last eight
			if (is_digit)
				num_acc_q <= num_acc_q * `FIX_NUM_W'(10) + `FIX_NUM_W'(digit);
		end
	end

endmodule

`default_nettype wire

// ==== logic/fix_checksum.sv ====
// FIX checksum: modulo-256 byte sum per message, compared against the field 10 value
`default_nettype none

`include "fix_consts.svh"

module fix_checksum (
	input  logic       clk,
	input  logic       rst,
	input  logic       byte_valid_i,
	input  logic [7:0] byte_i,
	input  logic       val_valid_i,
	input  logic       eom_i,
	output logic       sum_valid_o,
	output logic       sum_ok_o
);

	logic       in_val_q;    // between '=' and SOH
	logic [7:0] sum_q;
	logic [7:0] snap_q;      // sum up to the latest SOH
	logic [7:0] snap_prev_q; // sum up to the SOH before that
	logic [7:0] val_acc_q;   // value digits, mod 256
	logic [7:0] val_last_q;
	logic       end_of_msg;

	assign end_of_msg = val_valid_i && eom_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_q       <= 8'h00;
			in_val_q    <= 1'b0;
			sum_valid_o <= 1'b0;
		end else begin
			sum_valid_o <= end_of_msg;
			if (end_of_msg)
				sum_q <= byte_valid_i ? byte_i : 8'h00; // next message may start here
			else if (byte_valid_i)
				sum_q <= sum_q + byte_i;
			if (byte_valid_i && byte_i == `FIX_SOH)
				in_val_q <= 1'b0;
			else if (byte_valid_i && !in_val_q && byte_i == `FIX_EQ)
				in_val_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid_i && byte_i == `FIX_SOH) begin
			snap_prev_q <= snap_q;
			snap_q      <= sum_q + byte_i;
			val_last_q  <= val_acc_q;
		end else if (byte_valid_i && !in_val_q && byte_i == `FIX_EQ) begin
			val_acc_q <= 8'h00;
		end else if (byte_valid_i && in_val_q && byte_i >= "0" && byte_i <= "9") begin
			val_acc_q <= val_acc_q * 8'd10 + {4'h0, byte_i[3:0]};
		end
		// snap_prev_q covers everything before "10="
		if (end_of_msg)
			sum_ok_o <= (snap_prev_q == val_last_q);
	end

endmodule

`default_nettype wire

// ==== logic/fix_msg_validator.sv ====
// FIX message validator: header order FSM, session field capture and per-message verdict
`default_nettype none

`include "fix_consts.svh"

module fix_msg_validator import fix_session_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tag_valid_i,
	input  logic                  val_valid_i,
	input  field_s                field_i,
	input  logic                  sum_valid_i,
	input  logic                  sum_ok_i,
	input  logic [`FIX_SEQ_W-1:0] expected_seq_i,
	output logic                  verdict_valid_o,
	output verdict_s              verdict_o
);

	vstate_e               state;
	msg_type_e             mtype_q;
	logic [`FIX_SEQ_W-1:0] seq_q;
	logic [`FIX_SEQ_W-1:0] new_seq_q;
	logic                  poss_dup_q;
	logic                  gap_fill_q;
	logic                  has_sender_q;
	logic                  has_target_q;
	logic                  has_time_q;
	msg_type_e             rx_type;
	msg_type_e             fin_mtype;
	err_e                  fin_err;
	logic                  is_reset;

	function automatic logic version_ok(input logic [`FIX_VAL_W-1:0] raw);
		return (raw[`FIX_VAL_W-1:8] == {8'h00, `FIX_VER_PREFIX}) &&
			(raw[7:0] >= "0") && (raw[7:0] <= `FIX_VER_MAX);
	endfunction

	function automatic msg_type_e decode_type(input logic [`FIX_VAL_W-1:0] raw);
		if (raw[`FIX_VAL_W-1:8] != '0)
			return mt_none; // only single character types
		case (raw[7:0])
			"A":     return mt_logon;
			"0":     return mt_heartbeat;
			"1":     return mt_test_request;
			"2":     return mt_resend_request;
			"3":     return mt_reject;
			"4":     return mt_seq_reset;
			"5":     return mt_logout;
			default: return mt_none;
		endcase
	endfunction

	// header faults carry no type so the seq tracker leaves them alone
	function automatic verdict_s early_verdict(input err_e e);
		return '{mtype: mt_none, err: e, seq: seq_q, new_seq: new_seq_q, poss_dup: poss_dup_q};
	endfunction

	assign rx_type  = decode_type(field_i.raw);
	assign is_reset = (mtype_q == mt_seq_reset);

	always_comb begin
		fin_mtype = (is_reset && gap_fill_q) ? mt_gap_fill : mtype_q;
		if (!sum_ok_i)
			fin_err = err_garbled;
		else if (!(has_sender_q && has_target_q && has_time_q))
			fin_err = err_required_tag_missing;
		else if (seq_q < expected_seq_i && !poss_dup_q && !(is_reset && !gap_fill_q))
			fin_err = err_seq_low;
		else if (seq_q > expected_seq_i)
			fin_err = err_seq_high;
		else
			fin_err = err_ok;
	end

	always_ff @(posedge clk) begin
		verdict_valid_o <= 1'b0;
		if (rst) begin
			state        <= vs_idle;
			poss_dup_q   <= 1'b0;
			gap_fill_q   <= 1'b0;
			has_sender_q <= 1'b0;
			has_target_q <= 1'b0;
			has_time_q   <= 1'b0;
		end else if (tag_valid_i && field_i.som) begin
			// BeginString anywhere starts a new message
			state        <= vs_version;
			mtype_q      <= mt_none;
			seq_q        <= '0;
			new_seq_q    <= '0;
			poss_dup_q   <= 1'b0;
			gap_fill_q   <= 1'b0;
			has_sender_q <= 1'b0;
			has_target_q <= 1'b0;
			has_time_q   <= 1'b0;
		end else begin
			case (state)
				vs_idle: state <= vs_idle; // rest of a rejected message is dropped
				vs_version: if (val_valid_i) begin
					if (version_ok(field_i.raw)) begin
						state <= vs_body_tag;
					end else begin
						verdict_valid_o <= 1'b1;
						verdict_o       <= early_verdict(err_unsupported_version);
						state           <= vs_idle;
					end
				end
				vs_body_tag: if (tag_valid_i) begin
					if (field_i.tag == `T_BODY_LENGTH) begin
						state <= vs_body_val;
					end else begin
						verdict_valid_o <= 1'b1;
						verdict_o       <= early_verdict(err_garbled);
						state           <= vs_idle;
					end
				end
				vs_body_val: if (val_valid_i) state <= vs_type_tag; // length not checked
				vs_type_tag: if (tag_valid_i) begin
					if (field_i.tag == `T_MSG_TYPE) begin
						state <= vs_type_val;
					end else begin
						verdict_valid_o <= 1'b1;
						verdict_o       <= early_verdict(err_garbled);
						state           <= vs_idle;
					end
				end
				vs_type_val: if (val_valid_i) begin
					if (rx_type != mt_none) begin
						mtype_q <= rx_type;
						state   <= vs_seq_tag;
					end else begin
						verdict_valid_o <= 1'b1;
						verdict_o       <= early_verdict(err_invalid_msg_type);
						state           <= vs_idle;
					end
				end
				vs_seq_tag: if (tag_valid_i) begin
					if (field_i.tag == `T_MSG_SEQ_NUM) begin
						state <= vs_seq_val;
					end else begin
						verdict_valid_o <= 1'b1;
						verdict_o       <= early_verdict(err_garbled);
						state           <= vs_idle;
					end
				end
				vs_seq_val: if (val_valid_i) begin
					seq_q <= field_i.num;
					state <= vs_fields;
				end
				vs_fields: begin
					if (tag_valid_i && field_i.eom)
						state <= vs_wait_sum;
					if (val_valid_i) begin
						case (field_i.tag)
							`T_SENDER_COMP_ID: has_sender_q <= 1'b1;
							`T_TARGET_COMP_ID: has_target_q <= 1'b1;
							`T_SENDING_TIME:   has_time_q   <= 1'b1;
							`T_POSS_DUP:       poss_dup_q   <= (field_i.raw[7:0] == `FIX_CHAR_Y);
							`T_GAP_FILL:       gap_fill_q   <= (field_i.raw[7:0] == `FIX_CHAR_Y);
							`T_NEW_SEQ_NO:     new_seq_q    <= field_i.num;
							default:           state        <= vs_fields;
						endcase
					end
				end
				vs_wait_sum: if (sum_valid_i) begin
					verdict_valid_o <= 1'b1;
					verdict_o       <= '{mtype: fin_mtype, err: fin_err, seq: seq_q,
						new_seq: new_seq_q, poss_dup: poss_dup_q};
					state           <= vs_idle;
				end
				default: state <= vs_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/fix_seq_tracker.sv ====
// FIX sequence tracker: expected incoming MsgSeqNum, advanced or reloaded by verdicts
`default_nettype none

`include "fix_consts.svh"

module fix_seq_tracker import fix_session_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  verdict_valid_i,
	input  verdict_s              verdict_i,
	output logic [`FIX_SEQ_W-1:0] expected_seq_o
);

	logic verdict_ok;

	assign verdict_ok = (verdict_i.err == err_ok);

	always_ff @(posedge clk) begin
		if (rst) begin
			expected_seq_o <= `FIX_SEQ_W'(1); // sessions start at one
		end else if (verdict_valid_i) begin
			case (verdict_i.mtype)
				mt_seq_reset: begin
					expected_seq_o <= verdict_i.new_seq; // reset mode is unconditional
				end
				mt_gap_fill: begin
					if (verdict_ok)
						expected_seq_o <= verdict_i.new_seq;
				end
				default: begin
					if (verdict_ok)
						expected_seq_o <= expected_seq_o + `FIX_SEQ_W'(1);
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/fix_session_rx.sv ====
// FIX session receive top: parser, checksum, validator and sequence tracker
`default_nettype none

`include "fix_consts.svh"

module fix_session_rx import fix_session_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  byte_valid_i,
	input  logic [7:0]            byte_i,
	output logic                  verdict_valid_o,
	output verdict_s              verdict_o,
	output logic [`FIX_SEQ_W-1:0] expected_seq_o
);

	logic                  tag_valid;
	logic                  val_valid;
	field_s                field;
	logic                  sum_valid;
	logic                  sum_ok;
	logic [`FIX_SEQ_W-1:0] expected_seq;

	assign expected_seq_o = expected_seq;

	fix_tag_parser fix_tag_parser_inst (
		.clk          (clk),
		.rst          (rst),
		.byte_valid_i (byte_valid_i),
		.byte_i       (byte_i),
		.tag_valid_o  (tag_valid),
		.val_valid_o  (val_valid),
		.field_o      (field)
	);

	fix_checksum fix_checksum_inst (
		.clk          (clk),
		.rst          (rst),
		.byte_valid_i (byte_valid_i),
		.byte_i       (byte_i),
		.val_valid_i  (val_valid),
		.eom_i        (field.eom),
		.sum_valid_o  (sum_valid),
		.sum_ok_o     (sum_ok)
	);

	fix_msg_validator fix_msg_validator_inst (
		.clk             (clk),
		.rst             (rst),
		.tag_valid_i     (tag_valid),
		.val_valid_i     (val_valid),
		.field_i         (field),
		.sum_valid_i     (sum_valid),
		.sum_ok_i        (sum_ok),
		.expected_seq_i  (expected_seq),
		.verdict_valid_o (verdict_valid_o),
		.verdict_o       (verdict_o)
	);

	fix_seq_tracker fix_seq_tracker_inst (
		.clk             (clk),
		.rst             (rst),
		.verdict_valid_i (verdict_valid_o),
		.verdict_i       (verdict_o),
		.expected_seq_o  (expected_seq)
	);

endmodule

`default_nettype wire

// ==== tb/fix_session_rx_sva.sv ====
// FIX validator assertions on verdict strobe width, quiet reset and checksum answer timing
`default_nettype none

module fix_session_rx_sva import fix_session_pkg::*; (
	input logic    clk,
	input logic    rst,
	input logic    sum_valid_i,
	input logic    verdict_valid_i,
	input vstate_e state_i
);

	int unsigned fail_count = 0; // assertion failures so far

	verdict_one_wide: assert property (@(posedge clk) disable iff (rst)
		verdict_valid_i |=> !verdict_valid_i)
	else begin
		$error("verdict_valid lasted more than one cycle");
		fail_count++;
	end

	verdict_quiet_in_reset: assert property (@(posedge clk) rst |=> !verdict_valid_i)
	else begin
		$error("verdict_valid raised while in reset");
		fail_count++;
	end

	// a message still in progress must end with its checksum
	sum_answered: assert property (@(posedge clk) disable iff (rst)
		sum_valid_i && state_i != vs_idle |=> verdict_valid_i)
	else begin
		$error("sum_valid not followed by a verdict");
		fail_count++;
	end

endmodule

bind fix_msg_validator fix_session_rx_sva validator_sva_inst (
	.clk             (clk),
	.rst             (rst),
	.sum_valid_i     (sum_valid_i),
	.verdict_valid_i (verdict_valid_o),
	.state_i         (state)
);

`default_nettype wire

// ==== tb/fix_session_rx_tb.sv ====
// FIX session receive testbench: random FIX messages checked against a verdict reference model
`default_nettype none

`include "fix_consts.svh"

module fix_session_rx_tb import fix_session_pkg::*; ();

	localparam int N_MSG   = 200;
	localparam int MSG_MAX = 120; // longest message plus verdict wait and gap, in cycles
	localparam int LIMIT   = N_MSG * MSG_MAX + 200;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  byte_valid_i;
	logic [7:0]            byte_i;
	logic                  verdict_valid_o;
	verdict_s              verdict_o;
	logic [`FIX_SEQ_W-1:0] expected_seq_o;

	logic [31:0] rng_state;
	logic [31:0] model_seq; // expected_seq_o as the model sees it
	logic [7:0]  msg_q[$];
	verdict_s    got_q[$];  // verdicts seen on the output
	int unsigned cycles = 0;
	int unsigned test_errs;
	int unsigned passed = 0;
	int unsigned failed = 0;

	fix_session_rx fix_session_rx_inst (
		.clk             (clk),
		.rst             (rst),
		.byte_valid_i    (byte_valid_i),
		.byte_i          (byte_i),
		.verdict_valid_o (verdict_valid_o),
		.verdict_o       (verdict_o),
		.expected_seq_o  (expected_seq_o)
	);

	always #4 clk = ~clk;

	always @(negedge clk) begin
		if (verdict_valid_o)
			got_q.push_back(verdict_o);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout after %0d cycles", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic int unsigned pick(input int unsigned n);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return (rng_state >> 12) % n;
	endfunction

	function automatic msg_type_e type_of(input byte c, input logic gap);
		case (c)
			"A":     return mt_logon;
			"0":     return mt_heartbeat;
			"1":     return mt_test_request;
			"2":     return mt_resend_request;
			"3":     return mt_reject;
			"4":     return gap ? mt_gap_fill : mt_seq_reset;
			default: return mt_logout;
		endcase
	endfunction

	task automatic add_field(input int unsigned tag, input string val);
		string s;
		s = $sformatf("%0d=%s", tag, val);
		for (int i = 0; i < s.len(); i++)
			msg_q.push_back(s[i]);
		msg_q.push_back(`FIX_SOH);
	endtask

	task automatic check_field(input string name, input logic [31:0] exp_val,
		input logic [31:0] got_val);
		assert (exp_val == got_val) else begin
			$display("error %s exp 0x%0h got 0x%0h", name, exp_val, got_val);
			test_errs++;
		end
	endtask

	task automatic record_result(input int unsigned n, input verdict_s exp_v);
		$display("test %0d mtype 0x%0h err 0x%0h seq 0x%0h: %s", n, exp_v.mtype, exp_v.err,
			exp_v.seq, (test_errs == 0) ? "ok" : "mismatch");
		if (test_errs == 0)
			passed++;
		else
			failed++;
	endtask

	task automatic build_message(output verdict_s exp_v);
		string       types = "A012345";
		int unsigned fault, missing, pdup, sel, sum;
		logic [31:0] seq;
		logic [31:0] nsq;
		byte         tc;
		logic        gap;
		logic        bad_sum;
		msg_q.delete();
		fault   = pick(10); // 0 tag order, 1 version, 2 msg type, rest reach field 10
		tc      = types[pick(7)];
		gap     = (tc == "4") && (pick(2) == 1);
		missing = pick(12); // 0, 1, 2 drop 49, 56, 52
		pdup    = pick(4);  // 0 Y, 1 N, else absent
		bad_sum = (pick(8) == 0);
		nsq     = 1 + pick(40);
		sel     = pick(4);
		if (sel == 0 && model_seq > 1)
			seq = model_seq - 1;
		else if (sel == 1)
			seq = model_seq + 1 + pick(3);
		else
			seq = model_seq;
		add_field(8, $sformatf("FIX.4.%0d", (fault == 1) ? 4 + pick(6) : pick(4)));
		add_field(9, "64");
		if (fault == 0) begin
			add_field(34, $sformatf("%0d", seq)); // MsgSeqNum ahead of MsgType
			add_field(35, $sformatf("%c", tc));
		end else begin
			add_field(35, (fault == 2) ? "X" : $sformatf("%c", tc));
			add_field(34, $sformatf("%0d", seq));
		end
		if (missing != 0)
			add_field(49, "SNDR");
		if (missing != 1)
			add_field(56, "TRGT");
		if (missing != 2)
			add_field(52, "12:00:00");
		if (pdup < 2)
			add_field(43, (pdup == 0) ? "Y" : "N");
		if (tc == "4") begin
			if (gap)
				add_field(123, "Y");
			add_field(36, $sformatf("%0d", nsq));
		end
		sum = bad_sum;
		foreach (msg_q[i])
			sum += msg_q[i];
		add_field(10, $sformatf("%03d", sum % 256));

		exp_v = '0; // header faults carry no type and no captured fields
		if (fault == 0)
			exp_v.err = err_garbled;
		else if (fault == 1)
			exp_v.err = err_unsupported_version;
		else if (fault == 2)
			exp_v.err = err_invalid_msg_type;
		else begin
			exp_v.mtype    = type_of(tc, gap);
			exp_v.seq      = seq;
			exp_v.new_seq  = (tc == "4") ? nsq : 0;
			exp_v.poss_dup = (pdup == 0);
			if (bad_sum)
				exp_v.err = err_garbled;
			else if (missing < 3)
				exp_v.err = err_required_tag_missing;
			else if (seq < model_seq && pdup != 0 && exp_v.mtype != mt_seq_reset)
				exp_v.err = err_seq_low;
			else if (seq > model_seq)
				exp_v.err = err_seq_high;
			else
				exp_v.err = err_ok;
			if (exp_v.mtype == mt_seq_reset)
				model_seq = nsq;
			else if (exp_v.mtype == mt_gap_fill && exp_v.err == err_ok)
				model_seq = nsq;
			else if (exp_v.mtype != mt_gap_fill && exp_v.err == err_ok)
				model_seq = model_seq + 1;
		end
	endtask

	initial begin
		verdict_s    exp_v;
		verdict_s    got_v;
		int unsigned waited;
		int unsigned sva_errs;
		rst          = 1'b1;
		byte_valid_i = 1'b0;
		byte_i       = 8'h00;
		rng_state    = 32'd82865;
		model_seq    = 1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		test_errs = 0;
		check_field("expected_seq_o", 1, expected_seq_o);
		assert (got_q.size() == 0) else begin
			$display("a verdict appeared before any message was sent");
			test_errs++;
		end
		record_result(0, '0);

		for (int n = 1; n <= N_MSG; n++) begin
			test_errs = 0;
			build_message(exp_v);
			foreach (msg_q[i]) begin
				@(posedge clk);
				byte_valid_i <= 1'b1;
				byte_i       <= msg_q[i];
			end
			@(posedge clk);
			byte_valid_i <= 1'b0;
			waited = 0;
			while (got_q.size() == 0 && waited < 20) begin
				@(negedge clk);
				waited++;
			end
			repeat (6) @(posedge clk); // idle gap before the next message
			@(negedge clk);
			assert (got_q.size() != 0) else begin
				$display("no verdict arrived for message %0d", n);
				test_errs++;
			end
			if (got_q.size() != 0) begin
				got_v = got_q.pop_front();
				check_field("verdict_o.mtype", exp_v.mtype, got_v.mtype);
				check_field("verdict_o.err", exp_v.err, got_v.err);
				check_field("verdict_o.seq", exp_v.seq, got_v.seq);
				check_field("verdict_o.new_seq", exp_v.new_seq, got_v.new_seq);
				check_field("verdict_o.poss_dup", exp_v.poss_dup, got_v.poss_dup);
			end
			assert (got_q.size() == 0) else begin
				$display("more than one verdict arrived for message %0d", n);
				test_errs++;
				got_q.delete();
			end
			check_field("expected_seq_o", model_seq, expected_seq_o);
			record_result(n, exp_v);
		end

		sva_errs = fix_session_rx_inst.fix_msg_validator_inst.validator_sva_inst.fail_count;
		$display("tests %0d passed %0d failed %0d assertion failures %0d", N_MSG + 1, passed,
			failed, sva_errs);
		if (failed == 0 && sva_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fix_session_rx.f ====
+incdir+logic
logic/fix_session_pkg.sv
logic/fix_tag_parser.sv
logic/fix_checksum.sv
logic/fix_msg_validator.sv
logic/fix_seq_tracker.sv
logic/fix_session_rx.sv
tb/fix_session_rx_sva.sv
tb/fix_session_rx_tb.sv

// ==== Bender.yml ====
package:
  name: fix_session_rx

sources:
  - include_dirs:
      - logic
    files:
      - logic/fix_session_pkg.sv
      - logic/fix_tag_parser.sv
      - logic/fix_checksum.sv
      - logic/fix_msg_validator.sv
      - logic/fix_seq_tracker.sv
      - logic/fix_session_rx.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/fix_session_rx_sva.sv
      - tb/fix_session_rx_tb.sv
